// ==== all.f ====
source/ntm_math_pkg.sv
source/ntm_control_pkg.sv
source/ntm_scalar_if.sv
source/ntm_scalar_adder.sv
source/ntm_scalar_multiplier.sv
source/ntm_matrix_inversion.sv
testbench/ntm_matrix_inversion_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module ntm_matrix_inversion_tb \
  -f all.f --Mdir obj_dir

# tee keeps the log even when the run stops on an error
./obj_dir/Vntm_matrix_inversion_tb 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  exit 1
fi
exit 0

// ==== source/ntm_control_pkg.sv ====
`default_nettype none

package ntm_control_pkg;

  // Fixed 2x2 matrix, row-major
  localparam int MATRIX_ELEMENTS    = 4;
  localparam int ELEMENT_INDEX_SIZE = $clog2(MATRIX_ELEMENTS);

  typedef logic [ELEMENT_INDEX_SIZE-1:0] element_index_t;

  // Positions of a, b, c, d in the stream
  localparam element_index_t ELEM_A       = 2'd0;
  localparam element_index_t ELEM_B       = 2'd1;
  localparam element_index_t ELEM_C       = 2'd2;
  localparam element_index_t ELEM_D       = 2'd3;
  localparam element_index_t LAST_ELEMENT = element_index_t'(MATRIX_ELEMENTS - 1);

  // Controller steps, in run order
  typedef enum logic [3:0] {
    STARTER,
    LOAD,
    DET_MUL_AD,
    DET_MUL_BC,
    DET_SUB,
    EXP_SQUARE,
    EXP_MULTIPLY,
    ADJ_NEGATE,
    ADJ_SCALE,
    EMIT,
    ENDER
  } inversion_state_t;

endpackage : ntm_control_pkg

`default_nettype wire

// ==== source/ntm_math_pkg.sv ====
`default_nettype none

package ntm_math_pkg;

  //////////////////////////////////////////////////////////////////////
  // Word widths
  //////////////////////////////////////////////////////////////////////

  // Residues and modulus share one width
  localparam int DATA_SIZE = 16;

  // Counts 0..DATA_SIZE for operand and exponent bits
  localparam int BIT_COUNT_SIZE = 5;

  typedef logic [DATA_SIZE-1:0]      data_word_t;
  typedef logic [BIT_COUNT_SIZE-1:0] bit_count_t;

  //////////////////////////////////////////////////////////////////////
  // Adder operation codes
  //////////////////////////////////////////////////////////////////////

  localparam logic ADDER_ADD = 1'b0;
  localparam logic ADDER_SUB = 1'b1;

endpackage : ntm_math_pkg

`default_nettype wire

// ==== source/ntm_matrix_inversion.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntm_matrix_inversion
  import ntm_math_pkg::*;
  import ntm_control_pkg::*;
  (
    input  logic       CLK,
    input  logic       RST,

    input  logic       START,
    output logic       READY,

    input  logic       DATA_IN_I_ENABLE,
    input  logic       DATA_IN_J_ENABLE,
    output logic       DATA_OUT_I_ENABLE,
    output logic       DATA_OUT_J_ENABLE,

    input  data_word_t MODULO_IN,
    input  data_word_t DATA_IN,
    output data_word_t DATA_OUT
  );

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  inversion_state_t state;
  logic             pending;      // operator started and waiting on ready
  element_index_t   index;
  bit_count_t       exp_bit;

  // Element buffers
  data_word_t elements [MATRIX_ELEMENTS];
  data_word_t adjugate [MATRIX_ELEMENTS];   // d, -b, -c, a
  data_word_t result   [MATRIX_ELEMENTS];

  data_word_t modulo_reg;
  data_word_t exponent;
  data_word_t exponent_shifted;
  logic       exponent_bit;
  data_word_t product_ad;
  data_word_t product_bc;
  data_word_t det;
  data_word_t power;          // running power that ends as det^-1

  logic uses_adder;
  logic uses_multiplier;
  logic op_done;

  ntm_scalar_if adder_bus ();
  ntm_scalar_if multiplier_bus ();

  // Scalar operators
  ntm_scalar_adder scalar_adder (
    .CLK (CLK),
    .RST (RST),
    .bus (adder_bus)
  );

  ntm_scalar_multiplier scalar_multiplier (
    .CLK (CLK),
    .RST (RST),
    .bus (multiplier_bus)
  );

  //////////////////////////////////////////////////////////////////////
  // Operator requests
  //////////////////////////////////////////////////////////////////////

  assign uses_adder      = (state == DET_SUB) || (state == ADJ_NEGATE);
  assign uses_multiplier = (state == DET_MUL_AD) || (state == DET_MUL_BC) ||
                           (state == EXP_SQUARE) || (state == EXP_MULTIPLY) ||
                           (state == ADJ_SCALE);
  assign op_done = pending && (adder_bus.ready || multiplier_bus.ready);

  // Exponent walked MSB first
  assign exponent_shifted = exponent >> exp_bit;
  assign exponent_bit     = exponent_shifted[0];

  // Operands follow the state and hold until ready
  always_comb begin
    adder_bus.modulo    = modulo_reg;
    adder_bus.operation = ADDER_SUB;      // det and negation both subtract
    adder_bus.data_a    = '0;
    adder_bus.data_b    = '0;
    if (state == DET_SUB) begin
      adder_bus.data_a = product_ad;
      adder_bus.data_b = product_bc;
    end else if (state == ADJ_NEGATE) begin
      // 0 - b, 0 - c
      adder_bus.data_b = elements[index];
    end

    multiplier_bus.modulo    = modulo_reg;
    multiplier_bus.operation = ADDER_ADD; // not looked at
    case (state)
      DET_MUL_AD: begin
        multiplier_bus.data_a = elements[ELEM_A];
        multiplier_bus.data_b = elements[ELEM_D];
      end
      DET_MUL_BC: begin
        multiplier_bus.data_a = elements[ELEM_B];
        multiplier_bus.data_b = elements[ELEM_C];
      end
      EXP_SQUARE: begin
        multiplier_bus.data_a = power;
        multiplier_bus.data_b = power;
      end
      EXP_MULTIPLY: begin
        multiplier_bus.data_a = power;
        multiplier_bus.data_b = det;
      end
      ADJ_SCALE: begin
        multiplier_bus.data_a = power;
        multiplier_bus.data_b = adjugate[index];
      end
      default: begin
        multiplier_bus.data_a = '0;
        multiplier_bus.data_b = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Controller
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state                <= STARTER;
      pending              <= 1'b0;
      index                <= '0;
      exp_bit              <= '0;
      adder_bus.start      <= 1'b0;
      multiplier_bus.start <= 1'b0;
      READY                <= 1'b0;
      DATA_OUT_I_ENABLE    <= 1'b0;
      DATA_OUT_J_ENABLE    <= 1'b0;
      DATA_OUT             <= '0;
    end else begin
      adder_bus.start      <= 1'b0;
      multiplier_bus.start <= 1'b0;
      READY                <= 1'b0;
      DATA_OUT_I_ENABLE    <= 1'b0;
      DATA_OUT_J_ENABLE    <= 1'b0;

      // One start pulse per operation state visit
      if ((uses_adder || uses_multiplier) && !pending) begin
        adder_bus.start      <= uses_adder;
        multiplier_bus.start <= uses_multiplier;
        pending              <= 1'b1;
      end
      if (op_done) begin
        pending <= 1'b0;
      end

      case (state)
        STARTER: begin
          if (START) begin
            index <= ELEM_A;
            state <= LOAD;
          end
        end
        LOAD: begin
          if (DATA_IN_J_ENABLE) begin
            if (index == LAST_ELEMENT) begin
              state <= DET_MUL_AD;
            end else begin
              index <= index + 1'b1;
            end
          end
        end
        DET_MUL_AD: if (op_done) state <= DET_MUL_BC;
        DET_MUL_BC: if (op_done) state <= DET_SUB;
        DET_SUB: begin
          if (op_done) begin
            exp_bit <= bit_count_t'(DATA_SIZE - 1);
            state   <= EXP_SQUARE;
          end
        end
        EXP_SQUARE: begin
          if (op_done) begin
            if (exponent_bit) begin
              state <= EXP_MULTIPLY;
            end else if (exp_bit == '0) begin
              index <= ELEM_B;
              state <= ADJ_NEGATE;
            end else begin
              exp_bit <= exp_bit - 1'b1;
            end
          end
        end
        EXP_MULTIPLY: begin
          if (op_done) begin
            if (exp_bit == '0) begin
              index <= ELEM_B;
              state <= ADJ_NEGATE;
            end else begin
              exp_bit <= exp_bit - 1'b1;
              state   <= EXP_SQUARE;
            end
          end
        end
        ADJ_NEGATE: begin
          if (op_done) begin
            if (index == ELEM_C) begin
              index <= ELEM_A;
              state <= ADJ_SCALE;
            end else begin
              index <= ELEM_C;
            end
          end
        end
        ADJ_SCALE: begin
          if (op_done) begin
            if (index == LAST_ELEMENT) begin
              index <= ELEM_A;
              state <= EMIT;
            end else begin
              index <= index + 1'b1;
            end
          end
        end
        EMIT: begin
          // Row starts on even elements
          DATA_OUT          <= result[index];
          DATA_OUT_J_ENABLE <= 1'b1;
          DATA_OUT_I_ENABLE <= ~index[0];
          if (index == LAST_ELEMENT) begin
            state <= ENDER;
          end else begin
            index <= index + 1'b1;
          end
        end
        ENDER: begin
          READY <= 1'b1;
          state <= STARTER;
        end
        default: state <= STARTER;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath captures
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == STARTER && START) begin
      modulo_reg <= MODULO_IN;
      exponent   <= MODULO_IN - data_word_t'(2);   // Fermat
    end
    if (state == LOAD && DATA_IN_J_ENABLE) begin
      elements[index] <= DATA_IN;
      // Diagonal swaps straight into the adjugate
      if (index == ELEM_A) adjugate[ELEM_D] <= DATA_IN;
      if (index == ELEM_D) adjugate[ELEM_A] <= DATA_IN;
    end
    if (multiplier_bus.ready) begin
      case (state)
        DET_MUL_AD:               product_ad    <= multiplier_bus.data_out;
        DET_MUL_BC:               product_bc    <= multiplier_bus.data_out;
        EXP_SQUARE, EXP_MULTIPLY: power         <= multiplier_bus.data_out;
        ADJ_SCALE:                result[index] <= multiplier_bus.data_out;
        default: ;
      endcase
    end
    if (adder_bus.ready) begin
      if (state == DET_SUB) begin
        det   <= adder_bus.data_out;
        power <= data_word_t'(1);
      end else if (state == ADJ_NEGATE) begin
        adjugate[index] <= adder_bus.data_out;
      end
    end
  end

  assert property (@(posedge CLK) disable iff (RST) START |-> state == STARTER)
    else $error("START while a run is in progress");

  assert property (@(posedge CLK) disable iff (RST)
    (DATA_IN_I_ENABLE || DATA_IN_J_ENABLE) |-> state == LOAD)
    else $error("input element outside LOAD");

  assert property (@(posedge CLK) disable iff (RST) DATA_IN_I_ENABLE |-> DATA_IN_J_ENABLE)
    else $error("row strobe without element strobe");

endmodule : ntm_matrix_inversion

`default_nettype wire

// ==== source/ntm_scalar_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_adder
  import ntm_math_pkg::*;
  (
    input logic CLK,
    input logic RST,

    ntm_scalar_if.slave bus
  );

  // One extra bit for carry and borrow
  logic [DATA_SIZE:0] sum;
  logic [DATA_SIZE:0] diff;
  logic [DATA_SIZE:0] wrapped;

  always_comb begin
    sum  = {1'b0, bus.data_a} + {1'b0, bus.data_b};
    diff = {1'b0, bus.data_a} - {1'b0, bus.data_b};
    if (bus.operation == ADDER_ADD) begin
      // Sum below 2*modulo, one subtraction is enough
      wrapped = (sum >= {1'b0, bus.modulo}) ? sum - {1'b0, bus.modulo} : sum;
    end else begin
      // Top bit set means borrow
      wrapped = diff[DATA_SIZE] ? diff + {1'b0, bus.modulo} : diff;
    end
  end

  // Ready one cycle after start
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.start;
    end
  end

  always_ff @(posedge CLK) begin
    if (bus.start) begin
      bus.data_out <= wrapped[DATA_SIZE-1:0];
    end
  end

  // Result stays a residue
  assert property (@(posedge CLK) disable iff (RST)
    bus.ready |-> bus.data_out < bus.modulo)
    else $error("adder result not below modulus");

endmodule : ntm_scalar_adder

`default_nettype wire

// ==== source/ntm_scalar_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ntm_scalar_if
  import ntm_math_pkg::*;
  ();

  // Control
  logic start;
  logic ready;
  logic operation;

  // Data
  data_word_t modulo;
  data_word_t data_a;
  data_word_t data_b;
  data_word_t data_out;

  // Controller side, holds operands until ready
  modport master (
    output start,
    output operation,
    output modulo,
    output data_a,
    output data_b,
    input  ready,
    input  data_out
  );

  // Operator side
  modport slave (
    input  start,
    input  operation,
    input  modulo,
    input  data_a,
    input  data_b,
    output ready,
    output data_out
  );

endinterface : ntm_scalar_if

`default_nettype wire

// ==== source/ntm_scalar_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_multiplier
  import ntm_math_pkg::*;
  (
    input logic CLK,
    input logic RST,

    ntm_scalar_if.slave bus
  );

  //////////////////////////////////////////////////////////////////////
  // Step datapath
  //////////////////////////////////////////////////////////////////////

  logic       busy;
  bit_count_t count;        // steps still to run
  bit_count_t bit_index;
  data_word_t acc;
  data_word_t acc_base;
  data_word_t operand_shifted;
  data_word_t step_result;
  logic       step_bit;

  logic [DATA_SIZE:0] doubled;
  logic [DATA_SIZE:0] doubled_red;
  logic [DATA_SIZE:0] summed;
  logic [DATA_SIZE:0] summed_red;

  always_comb begin
    // First step runs in the start cycle from zero, MSB of data_b
    acc_base  = busy ? acc : '0;
    bit_index = busy ? count - 1'b1 : bit_count_t'(DATA_SIZE - 1);

    operand_shifted = bus.data_b >> bit_index;
    step_bit        = operand_shifted[0];

    // acc = 2*acc mod m
    doubled     = {acc_base, 1'b0};
    doubled_red = (doubled >= {1'b0, bus.modulo}) ? doubled - {1'b0, bus.modulo} : doubled;

    // acc += a mod m when the bit is set
    summed     = doubled_red + (step_bit ? {1'b0, bus.data_a} : '0);
    summed_red = (summed >= {1'b0, bus.modulo}) ? summed - {1'b0, bus.modulo} : summed;

    step_result = summed_red[DATA_SIZE-1:0];
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////////////////////////

  // Start: step 1, then 15 more, then one cycle to publish
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      count     <= '0;
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= 1'b0;
      if (bus.start) begin
        busy  <= 1'b1;
        count <= bit_count_t'(DATA_SIZE - 1);
      end else if (busy) begin
        if (count == '0) begin
          busy      <= 1'b0;
          bus.ready <= 1'b1;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (bus.start || (busy && count != '0)) begin
      acc <= step_result;
    end
    // Final cycle
    if (busy && count == '0) begin
      bus.data_out <= acc;
    end
  end

  assert property (@(posedge CLK) disable iff (RST) bus.ready |=> !bus.ready)
    else $error("multiplier ready longer than one cycle");

  // Controller waits for ready before the next start
  assert property (@(posedge CLK) disable iff (RST) bus.start |-> !busy)
    else $error("multiplier started while busy");

endmodule : ntm_scalar_multiplier

`default_nettype wire

// ==== testbench/ntm_matrix_inversion_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ntm_matrix_inversion_tb
  import ntm_math_pkg::*;
  import ntm_control_pkg::*;
  ();

  // Twenty runs of up to about 750 cycles with a wide margin
  localparam int         MAX_CYCLES  = 40000;
  localparam data_word_t PRIME_LARGE = 16'd65521;

  logic       CLK = 1'b0;
  logic       RST;
  logic       START;
  logic       READY;
  logic       DATA_IN_I_ENABLE;
  logic       DATA_IN_J_ENABLE;
  logic       DATA_OUT_I_ENABLE;
  logic       DATA_OUT_J_ENABLE;
  data_word_t MODULO_IN;
  data_word_t DATA_IN;
  data_word_t DATA_OUT;

  integer      seed = 61;
  int          cycle_count = 0;
  logic [63:0] expected_queue [$];   // packed {r0, r1, r2, r3} per run

  // Output burst capture
  data_word_t  captured_data  [MATRIX_ELEMENTS];
  logic        captured_i     [MATRIX_ELEMENTS];
  int          captured_cycle [MATRIX_ELEMENTS];
  int          captured_count = 0;

  ntm_matrix_inversion UUT (
    .CLK               (CLK),
    .RST               (RST),
    .START             (START),
    .READY             (READY),
    .DATA_IN_I_ENABLE  (DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE  (DATA_IN_J_ENABLE),
    .DATA_OUT_I_ENABLE (DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE (DATA_OUT_J_ENABLE),
    .MODULO_IN         (MODULO_IN),
    .DATA_IN           (DATA_IN),
    .DATA_OUT          (DATA_OUT)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////////////////////////

  // Inverse of [a b; c d] mod m with det^-1 by Fermat
  function automatic logic [63:0] reference_inverse(input data_word_t m, a, b, c, d);
    logic [63:0] mod_w;
    logic [63:0] det;
    logic [63:0] inv;
    logic [63:0] base;
    logic [63:0] e;
    logic [63:0] adj [MATRIX_ELEMENTS];
    logic [63:0] packed_result;
    mod_w = 64'(m);
    // Kept non-negative by adding m before the subtraction
    det  = ((64'(a) * 64'(d)) % mod_w + mod_w - (64'(b) * 64'(c)) % mod_w) % mod_w;
    inv  = 64'd1;
    base = det;
    e    = mod_w - 64'd2;
    while (e != 64'd0) begin
      if (e[0]) inv = (inv * base) % mod_w;
      base = (base * base) % mod_w;
      e    = e >> 1;
    end
    adj[0] = 64'(d);
    adj[1] = (mod_w - 64'(b)) % mod_w;
    adj[2] = (mod_w - 64'(c)) % mod_w;
    adj[3] = 64'(a);
    for (int k = 0; k < MATRIX_ELEMENTS; k++) begin
      packed_result[63 - 16*k -: 16] = data_word_t'((adj[k] * inv) % mod_w);
    end
    return packed_result;
  endfunction

  function automatic data_word_t random_below(input data_word_t m);
    return data_word_t'($unsigned($random(seed)) % 32'(m));
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input data_word_t expected,
                            input data_word_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("Mismatch at %0t: %s expected 0x%04h, got 0x%04h",
                              $time, name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("Mismatch at %0t: %s expected %b, got %b",
                              $time, name, expected, actual));
    end
  endtask

  // Burst of one run against the oldest queued expectation
  task automatic compare_run();
    logic [63:0] expected;
    int          k;
    if (captured_count != MATRIX_ELEMENTS) begin
      stop_on_error($sformatf("READY after %0d output elements instead of four",
                              captured_count));
    end
    if (expected_queue.size() == 0) begin
      stop_on_error("READY pulsed with no run started");
    end
    expected = expected_queue.pop_front();
    if (cycle_count != captured_cycle[MATRIX_ELEMENTS-1] + 1) begin
      stop_on_error("READY not on the cycle after the last output element");
    end
    for (k = 0; k < MATRIX_ELEMENTS; k++) begin
      if (k > 0 && captured_cycle[k] != captured_cycle[k-1] + 1) begin
        stop_on_error("output elements not on consecutive cycles");
      end
      check_word($sformatf("DATA_OUT[%0d]", k), expected[63 - 16*k -: 16], captured_data[k]);
      check_flag($sformatf("DATA_OUT_I_ENABLE[%0d]", k), (k % 2) == 0, captured_i[k]);
    end
    captured_count = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Collector and timeout
  //////////////////////////////////////////////////////////////////////

  // Outputs settle after the rising edge and are sampled on the falling one
  always @(negedge CLK) begin
    if (!RST) begin
      if (DATA_OUT_I_ENABLE && !DATA_OUT_J_ENABLE) begin
        stop_on_error("output row strobe without an element strobe");
      end
      if (DATA_OUT_J_ENABLE) begin
        if (captured_count >= MATRIX_ELEMENTS) begin
          stop_on_error("more than four output elements before READY");
        end
        captured_data[captured_count]  = DATA_OUT;
        captured_i[captured_count]     = DATA_OUT_I_ENABLE;
        captured_cycle[captured_count] = cycle_count;
        captured_count                 = captured_count + 1;
      end
      if (READY) compare_run();
    end
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      stop_on_error("Timeout, the runs did not finish within the cycle limit");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Called 1 ns after a rising edge and returns the same way
  task automatic run_matrix(input data_word_t m, a, b, c, d, input logic use_gaps);
    data_word_t elems [MATRIX_ELEMENTS];
    int         gap;
    int         k;
    elems[0] = a;
    elems[1] = b;
    elems[2] = c;
    elems[3] = d;
    expected_queue.push_back(reference_inverse(m, a, b, c, d));
    START     = 1'b1;
    MODULO_IN = m;
    @(posedge CLK);
    #1;
    START = 1'b0;
    for (k = 0; k < MATRIX_ELEMENTS; k++) begin
      gap = use_gaps ? int'($unsigned($random(seed)) % 32'd4) : 0;
      repeat (gap) begin
        @(posedge CLK);
        #1;
      end
      DATA_IN          = elems[k];
      DATA_IN_J_ENABLE = 1'b1;
      DATA_IN_I_ENABLE = (k % 2) == 0;   // row start
      @(posedge CLK);
      #1;
      DATA_IN_J_ENABLE = 1'b0;
      DATA_IN_I_ENABLE = 1'b0;
    end
    // Next run starts right behind READY
    @(negedge CLK);
    while (!READY) @(negedge CLK);
    @(posedge CLK);
    #1;
  endtask

  initial begin
    int r;
    RST              = 1'b1;
    START            = 1'b0;
    MODULO_IN        = '0;
    DATA_IN          = '0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Idle outputs after reset
    @(negedge CLK);
    check_flag("READY", 1'b0, READY);
    check_flag("DATA_OUT_I_ENABLE", 1'b0, DATA_OUT_I_ENABLE);
    check_flag("DATA_OUT_J_ENABLE", 1'b0, DATA_OUT_J_ENABLE);
    check_word("DATA_OUT", 16'd0, DATA_OUT);
    @(posedge CLK);
    #1;

    run_matrix(PRIME_LARGE, 16'd1, 16'd0, 16'd0, 16'd1, 1'b0);

    for (r = 0; r < 12; r++) begin
      run_matrix(PRIME_LARGE, random_below(PRIME_LARGE), random_below(PRIME_LARGE),
                 random_below(PRIME_LARGE), random_below(PRIME_LARGE), 1'b1);
    end

    // Small moduli wrap often
    for (r = 0; r < 3; r++) begin
      run_matrix(16'd7, random_below(16'd7), random_below(16'd7),
                 random_below(16'd7), random_below(16'd7), 1'b1);
    end
    for (r = 0; r < 3; r++) begin
      run_matrix(16'd13, random_below(16'd13), random_below(16'd13),
                 random_below(16'd13), random_below(16'd13), 1'b1);
    end

    // Singular matrix with det = 0
    run_matrix(PRIME_LARGE, 16'd2, 16'd4, 16'd1, 16'd2, 1'b0);

    repeat (4) @(posedge CLK);
    $display("STATUS: PASS");
    $finish;
  end

endmodule : ntm_matrix_inversion_tb

`default_nettype wire
